// File: build.f
logic/screen_pkg.sv
logic/palette_pkg.sv
logic/scroll_timer.sv
logic/note_history.sv
logic/key_panel.sv
logic/pixel_compose.sv
logic/vga_display.sv
dv/tb_vga_display.sv

// File: Makefile
TOP = tb_vga_display

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f build.f --top-module $(TOP) -Mdir obj_dir

run: compile
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "PASS: all tests" sim.log

clean:
	rm -rf obj_dir sim.log

// File: dv/tb_vga_display.sv
`timescale 1ns/1ps
`default_nettype none

module tb_vga_display
	import screen_pkg::*;
	import palette_pkg::*;
();

	localparam int STEP_CYCLES    = 64;
	localparam int RESET_CYCLES   = 16;
	localparam int PANEL_PROBES   = 4000;
	localparam int SCROLL_ROUNDS  = 4;
	localparam int OVERLAP_PROBES = 32;
	localparam int OUTSIDE_PROBES = 600;
	localparam int TEST_CYCLES    = RESET_CYCLES + PANEL_PROBES
		+ SCROLL_ROUNDS * (HIST_ROWS + 2) * STEP_CYCLES
		+ NUM_BLACK * (STEP_CYCLES + OVERLAP_PROBES) + OUTSIDE_PROBES;
	localparam int TIMEOUT_CYCLES = TEST_CYCLES * 3 / 2;
	localparam logic [15:0] LFSR_SEED = 16'd76;

	logic       CLK_to_DAC;
	logic       RST_N;
	coord_t     x;
	coord_t     y;
	key_mask_t  ctrl;
	logic [7:0] vga_r;
	logic [7:0] vga_g;
	logic [7:0] vga_b;
	rgb_t       dut_rgb;

	// Reference history, row 0 newest
	key_mask_t   model_hist [HIST_ROWS];
	int          cycles_run;
	int          steps_seen;
	int          cycle_count = 0;
	logic [15:0] lfsr_state;
	string       test_name;
	string       name_q;
	int          overlap_key;
	rgb_t        exp_q;
	logic        outside_q;
	logic        ovl_active_q;
	rgb_t        ovl_colour_q;

	vga_display #(.SCROLL_PERIOD(STEP_CYCLES)) UUT (
		.CLK_to_DAC (CLK_to_DAC),
		.RST_N      (RST_N),
		.x          (x),
		.y          (y),
		.ctrl       (ctrl),
		.vga_r      (vga_r),
		.vga_g      (vga_g),
		.vga_b      (vga_b)
	);

	assign dut_rgb = {vga_r, vga_g, vga_b};

	always #5 CLK_to_DAC = ~CLK_to_DAC;

	// x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	task automatic take_bits(input int n, output int unsigned v);
		v = 0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_step(lfsr_state);
			v = {v[30:0], lfsr_state[0]};
		end
	endtask

	task automatic pick_range(input int lo, input int hi, output int v);
		int unsigned bits;
		take_bits(16, bits);
		v = lo + int'(bits % unsigned'(hi - lo + 1));
	endtask

	function automatic logic is_black_key(input int key);
		for (int b = 0; b < NUM_BLACK; b++) begin
			if (BLACK_KEY_IDX[b] == key) begin
				return 1'b1;
			end
		end
		return 1'b0;
	endfunction

	function automatic rgb_t panel_expected(input int px, input int py, input key_mask_t keys);
		rgb_t c;
		int   band;
		int   m;
		c = COL_WHITE;
		if (py >= 1) begin
			band = (py - 1) / WHITE_BAND;
			if (band < NUM_WHITE && keys[WHITE_KEY_IDX[band]]) begin
				c = COL_WHITE_LIT;
			end
		end
		if (px > BLACK_X_MIN) begin
			for (int b = 0; b < NUM_BLACK; b++) begin
				if (py > BLACK_BAR_LO[b] && py <= BLACK_BAR_HI[b]) begin
					c = keys[BLACK_KEY_IDX[b]] ? COL_BLACK_LIT : COL_BLACK;
				end
			end
			for (int s = 0; s < 4; s++) begin
				if (py > GAP_SEP[s] - SEP_HALF && py <= GAP_SEP[s] + SEP_HALF) begin
					c = COL_BLACK;
				end
			end
		end else begin
			// Line k covers y = 30k-1 .. 30k+2
			m = py + 1;
			if (m / WHITE_BAND >= 1 && m / WHITE_BAND < NUM_WHITE &&
				m % WHITE_BAND < 2 * SEP_HALF) begin
				c = COL_BLACK;
			end
		end
		return c;
	endfunction

	function automatic rgb_t waterfall_expected(input int px, input int py);
		int        row;
		int        col;
		int        first;
		key_mask_t keys;
		rgb_t      c;
		logic      black_drawn;
		row = (px - PANEL_X_MAX - 1) / ROW_PIXELS;
		if (row >= HIST_ROWS) begin
			return COL_BLACK;
		end
		col = (py == 0) ? 0 : (py - 1) / COL_PIXELS;
		keys = model_hist[row];
		c = COL_BLACK;
		black_drawn = 1'b0;
		for (int k = 0; k < NUM_KEYS; k++) begin
			first = NOTE_FIRST_COL[k];
			if (keys[k] && col >= first && col < first + NOTE_WIDTH[k]) begin
				if (is_black_key(k)) begin
					c = NOTE_COLOUR[k];
					black_drawn = 1'b1;
				end else if (!black_drawn) begin
					c = NOTE_COLOUR[k];
				end
			end
		end
		return c;
	endfunction

	function automatic rgb_t expected_colour(input int px, input int py, input key_mask_t keys);
		if (py > SCREEN_Y_MAX) begin
			return COL_BLACK;
		end
		if (px <= PANEL_X_MAX) begin
			return panel_expected(px, py, keys);
		end
		return waterfall_expected(px, py);
	endfunction

	function automatic logic is_outside(input int px, input int py);
		return (py > SCREEN_Y_MAX) ||
			(px > PANEL_X_MAX && (px - PANEL_X_MAX - 1) / ROW_PIXELS >= HIST_ROWS);
	endfunction

	task automatic report_mismatch(input string what, input rgb_t exp, input rgb_t act);
		$display("** Error [%s]: expected %06h, actual %06h", what, exp, act);
		$display("FAIL: see errors above");
		$fatal(1);
	endtask

	// Model history steps on every STEP_CYCLES-th edge after release
	always @(posedge CLK_to_DAC or negedge RST_N) begin
		if (!RST_N) begin
			cycles_run <= 0;
			steps_seen <= 0;
			for (int r = 0; r < HIST_ROWS; r++) begin
				model_hist[r] <= '0;
			end
		end else begin
			cycles_run <= cycles_run + 1;
			if ((cycles_run + 1) % STEP_CYCLES == 0) begin
				for (int r = HIST_ROWS - 1; r > 0; r--) begin
					model_hist[r] <= model_hist[r - 1];
				end
				model_hist[0] <= ctrl;
				steps_seen <= steps_seen + 1;
			end
		end
	end

	always @(posedge CLK_to_DAC or negedge RST_N) begin
		name_q <= test_name;
		if (!RST_N) begin
			exp_q <= COL_BLACK;
			outside_q <= 1'b0;
			ovl_active_q <= 1'b0;
			ovl_colour_q <= COL_BLACK;
		end else begin
			exp_q <= expected_colour(int'(x), int'(y), ctrl);
			outside_q <= is_outside(int'(x), int'(y));
			ovl_active_q <= (overlap_key >= 0);
			if (overlap_key >= 0) begin
				ovl_colour_q <= NOTE_COLOUR[overlap_key];
			end else begin
				ovl_colour_q <= COL_BLACK;
			end
		end
	end

	always @(posedge CLK_to_DAC) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("FAIL: see errors above");
			$fatal(1);
		end
	end

	// Outputs are registered, so the falling edge sees settled values
	a_reset_zero: assert property (
		@(negedge CLK_to_DAC) !RST_N |-> (dut_rgb == COL_BLACK)
	) else report_mismatch("reset", COL_BLACK, dut_rgb);

	a_output_match: assert property (
		@(negedge CLK_to_DAC) disable iff (!RST_N) dut_rgb == exp_q
	) else report_mismatch(name_q, exp_q, dut_rgb);

	a_outside_black: assert property (
		@(negedge CLK_to_DAC) disable iff (!RST_N) outside_q |-> (dut_rgb == COL_BLACK)
	) else report_mismatch("outside_regions", COL_BLACK, dut_rgb);

	a_black_wins: assert property (
		@(negedge CLK_to_DAC) disable iff (!RST_N) ovl_active_q |-> (dut_rgb == ovl_colour_q)
	) else report_mismatch("overlap_priority", ovl_colour_q, dut_rgb);

	task automatic drive_pixel(input int px, input int py, input key_mask_t keys, input int key);
		@(negedge CLK_to_DAC);
		x = coord_t'(px);
		y = coord_t'(py);
		ctrl = keys;
		overlap_key = key;
	endtask

	task automatic wait_steps(input int n);
		int target;
		target = steps_seen + n;
		while (steps_seen < target) begin
			@(negedge CLK_to_DAC);
		end
	endtask

	task automatic panel_sweep();
		int          px;
		int          py;
		int unsigned bits;
		test_name = "keyboard_panel";
		for (int i = 0; i < PANEL_PROBES; i++) begin
			pick_range(0, PANEL_X_MAX, px);
			pick_range(0, SCREEN_Y_MAX, py);
			take_bits(NUM_KEYS, bits);
			drive_pixel(px, py, bits[NUM_KEYS-1:0], -1);
		end
	endtask

	task automatic scroll_follow();
		key_mask_t   mask;
		int unsigned bits;
		int          px;
		int          py;
		int          target;
		test_name = "waterfall_scroll";
		for (int round = 0; round < SCROLL_ROUNDS; round++) begin
			wait_steps(1);
			take_bits(NUM_KEYS, bits);
			mask = bits[NUM_KEYS-1:0];
			target = steps_seen + 1;
			while (steps_seen < target) begin
				pick_range(0, PANEL_X_MAX, px);
				pick_range(0, SCREEN_Y_MAX, py);
				drive_pixel(px, py, mask, -1);
			end
			// The mask is in row 0 and moves one row per step
			for (int row = 0; row < HIST_ROWS; row++) begin
				target = steps_seen + 1;
				while (steps_seen < target) begin
					pick_range(0, ROW_PIXELS - 1, px);
					pick_range(0, SCREEN_Y_MAX, py);
					take_bits(NUM_KEYS, bits);
					drive_pixel(PANEL_X_MAX + 1 + row * ROW_PIXELS + px, py,
						bits[NUM_KEYS-1:0], -1);
				end
			end
		end
	endtask

	task automatic overlap_probe();
		key_mask_t mask;
		int        key;
		int        col;
		int        px;
		int        py;
		test_name = "overlap_priority";
		for (int b = 0; b < NUM_BLACK; b++) begin
			key = BLACK_KEY_IDX[b];
			mask = '0;
			mask[key - 1] = 1'b1;
			mask[key] = 1'b1;
			mask[key + 1] = 1'b1;
			drive_pixel(0, 0, mask, -1);
			wait_steps(1);
			for (int i = 0; i < OVERLAP_PROBES; i++) begin
				pick_range(NOTE_FIRST_COL[key], NOTE_FIRST_COL[key] + 1, col);
				pick_range(1 + col * COL_PIXELS, col * COL_PIXELS + COL_PIXELS, py);
				pick_range(PANEL_X_MAX + 1, PANEL_X_MAX + ROW_PIXELS, px);
				drive_pixel(px, py, mask, key);
			end
		end
	endtask

	task automatic outside_probe();
		int          px;
		int          py;
		int unsigned bits;
		test_name = "outside_regions";
		for (int i = 0; i < OUTSIDE_PROBES; i++) begin
			if (i % 2 == 0) begin
				pick_range(0, 2047, px);
				pick_range(SCREEN_Y_MAX + 1, 2047, py);
			end else begin
				pick_range(PANEL_X_MAX + 1 + HIST_ROWS * ROW_PIXELS, 2047, px);
				pick_range(0, SCREEN_Y_MAX, py);
			end
			take_bits(NUM_KEYS, bits);
			drive_pixel(px, py, bits[NUM_KEYS-1:0], -1);
		end
	endtask

	initial begin
		CLK_to_DAC = 1'b0;
		RST_N = 1'b0;
		// A lit white pixel, so a missing reset would show
		x = 11'd10;
		y = 11'd10;
		ctrl = '1;
		overlap_key = -1;
		test_name = "reset";
		lfsr_state = LFSR_SEED;
		repeat (RESET_CYCLES) @(negedge CLK_to_DAC);
		RST_N = 1'b1;
		panel_sweep();
		scroll_follow();
		overlap_probe();
		outside_probe();
		drive_pixel(0, 0, '0, -1);
		repeat (4) @(negedge CLK_to_DAC);
		$display("PASS: all tests");
		$finish;
	end

endmodule

`default_nettype wire

// File: logic/vga_display.sv
`timescale 1ns/1ps
`default_nettype none

module vga_display
	import screen_pkg::*;
	import palette_pkg::*;
#(
	parameter int SCROLL_PERIOD = screen_pkg::SCROLL_PERIOD
) (
	input  logic       CLK_to_DAC,
	input  logic       RST_N,
	input  coord_t     x,
	input  coord_t     y,
	input  key_mask_t  ctrl,
	output logic [7:0] vga_r,
	output logic [7:0] vga_g,
	output logic [7:0] vga_b
);

	pixel_pos_t pos;
	logic       step;
	rgb_t       panel_colour;
	logic       panel_hit;
	rgb_t       wave_colour;
	logic       wave_hit;
	rgb_t       rgb;

	assign pos.x = x;
	assign pos.y = y;

	scroll_timer #(.PERIOD(SCROLL_PERIOD)) u_scroll_timer (
		.CLK_to_DAC (CLK_to_DAC),
		.RST_N      (RST_N),
		.step       (step)
	);

	note_history u_note_history (
		.CLK_to_DAC (CLK_to_DAC),
		.RST_N      (RST_N),
		.step       (step),
		.ctrl       (ctrl),
		.pos        (pos),
		.colour     (wave_colour),
		.hit        (wave_hit)
	);

	key_panel u_key_panel (
		.ctrl   (ctrl),
		.pos    (pos),
		.colour (panel_colour),
		.hit    (panel_hit)
	);

	pixel_compose u_pixel_compose (
		.CLK_to_DAC   (CLK_to_DAC),
		.RST_N        (RST_N),
		.panel_colour (panel_colour),
		.panel_hit    (panel_hit),
		.wave_colour  (wave_colour),
		.wave_hit     (wave_hit),
		.rgb          (rgb)
	);

	assign vga_r = rgb.r;
	assign vga_g = rgb.g;
	assign vga_b = rgb.b;

endmodule

`default_nettype wire

// File: logic/pixel_compose.sv
`timescale 1ns/1ps
`default_nettype none

module pixel_compose
	import palette_pkg::*;
(
	input  logic CLK_to_DAC,
	input  logic RST_N,
	input  rgb_t panel_colour,
	input  logic panel_hit,
	input  rgb_t wave_colour,
	input  logic wave_hit,
	output rgb_t rgb
);

	rgb_t next_rgb;

	always_comb begin
		if (panel_hit) begin
			next_rgb = panel_colour;
		end else if (wave_hit) begin
			next_rgb = wave_colour;
		end else begin
			// Below the panel and past the screen edge
			next_rgb = COL_BLACK;
		end
	end

	always_ff @(posedge CLK_to_DAC or negedge RST_N) begin
		if (!RST_N) begin
			rgb <= '0;
		end else begin
			rgb <= next_rgb;
		end
	end

	// Panel and waterfall regions split at the same x edge
	a_regions_disjoint: assert property (
		@(posedge CLK_to_DAC) disable iff (!RST_N)
		!(panel_hit && wave_hit)
	);

endmodule

`default_nettype wire

// File: logic/key_panel.sv
`timescale 1ns/1ps
`default_nettype none

module key_panel
	import screen_pkg::*;
	import palette_pkg::*;
(
	input  key_mask_t  ctrl,
	input  pixel_pos_t pos,
	output rgb_t       colour,
	output logic       hit
);

	int px;
	int py;

	assign px = int'(pos.x);
	assign py = int'(pos.y);

	assign hit = (px <= PANEL_X_MAX) && (py <= SCREEN_Y_MAX);

	always_comb begin
		colour = COL_WHITE;

		// White bands, (30k, 30k+30]
		for (int k = 0; k < NUM_WHITE; k++) begin
			if (py > WHITE_BAND * k && py <= WHITE_BAND * (k + 1) &&
				ctrl[WHITE_KEY_IDX[k]]) begin
				colour = COL_WHITE_LIT;
			end
		end

		if (px > BLACK_X_MIN) begin
			for (int b = 0; b < NUM_BLACK; b++) begin
				if (py > BLACK_BAR_LO[b] && py <= BLACK_BAR_HI[b]) begin
					colour = ctrl[BLACK_KEY_IDX[b]] ? COL_BLACK_LIT : COL_BLACK;
				end
			end
			// E-F and B-C boundaries have no black bar to mark them
			for (int s = 0; s < 4; s++) begin
				if (py > GAP_SEP[s] - SEP_HALF && py <= GAP_SEP[s] + SEP_HALF) begin
					colour = COL_BLACK;
				end
			end
		end else begin
			// Full separators on the narrow left strip
			for (int k = 1; k < NUM_WHITE; k++) begin
				if (py > WHITE_BAND * k - SEP_HALF && py <= WHITE_BAND * k + SEP_HALF) begin
					colour = COL_BLACK;
				end
			end
		end
	end

endmodule

`default_nettype wire

// File: logic/note_history.sv
`timescale 1ns/1ps
`default_nettype none

module note_history
	import screen_pkg::*;
	import palette_pkg::*;
(
	input  logic       CLK_to_DAC,
	input  logic       RST_N,
	input  logic       step,
	input  key_mask_t  ctrl,
	input  pixel_pos_t pos,
	output rgb_t       colour,
	output logic       hit
);

	localparam int RW = $clog2(HIST_ROWS);
	localparam int CLW = $clog2(HIST_COLS);

	// Row 0 is the newest mask
	key_mask_t [HIST_ROWS-1:0] hist;

	coord_t        x_off;
	coord_t        y_off;
	coord_t        row_idx;
	logic [CLW-1:0] col_idx;
	key_mask_t     row_mask;

	function automatic logic in_note(input int key, input int col);
		int first;
		first = NOTE_FIRST_COL[key];
		return (col >= first) && (col < first + NOTE_WIDTH[key]);
	endfunction

	always_ff @(posedge CLK_to_DAC or negedge RST_N) begin
		if (!RST_N) begin
			hist <= '0;
		end else if (step) begin
			hist <= {hist[HIST_ROWS-2:0], ctrl};
		end
	end

	assign hit = (pos.x > coord_t'(PANEL_X_MAX)) && (pos.y <= coord_t'(SCREEN_Y_MAX));

	assign x_off = pos.x - coord_t'(PANEL_X_MAX + 1);
	assign row_idx = x_off / coord_t'(ROW_PIXELS);

	// y = 0 shares column 0 with y = 1..10
	assign y_off = (pos.y == '0) ? '0 : pos.y - 1'b1;
	assign col_idx = CLW'(y_off / coord_t'(COL_PIXELS));

	assign row_mask = (row_idx < coord_t'(HIST_ROWS)) ? hist[row_idx[RW-1:0]] : '0;

	always_comb begin
		colour = COL_BLACK;
		for (int k = 0; k < NUM_WHITE; k++) begin
			if (row_mask[WHITE_KEY_IDX[k]] && in_note(WHITE_KEY_IDX[k], int'(col_idx))) begin
				colour = NOTE_COLOUR[WHITE_KEY_IDX[k]];
			end
		end
		// Black notes sit over the shared edge columns
		for (int b = 0; b < NUM_BLACK; b++) begin
			if (row_mask[BLACK_KEY_IDX[b]] && in_note(BLACK_KEY_IDX[b], int'(col_idx))) begin
				colour = NOTE_COLOUR[BLACK_KEY_IDX[b]];
			end
		end
	end

endmodule

`default_nettype wire

// File: logic/scroll_timer.sv
`timescale 1ns/1ps
`default_nettype none

module scroll_timer
	import screen_pkg::*;
#(
	parameter int PERIOD = SCROLL_PERIOD
) (
	input  logic CLK_to_DAC,
	input  logic RST_N,
	output logic step
);

	localparam int CW = (PERIOD > 2) ? $clog2(PERIOD) : 1;

	logic [CW-1:0] count;

	assign step = (count == CW'(PERIOD - 1));

	always_ff @(posedge CLK_to_DAC or negedge RST_N) begin
		if (!RST_N) begin
			count <= '0;
		end else if (step) begin
			count <= '0;
		end else begin
			count <= count + 1'b1;
		end
	end

	// Wrap always passes through zero, so pulses are isolated
	a_step_single: assert property (
		@(posedge CLK_to_DAC) disable iff (!RST_N)
		step |=> !step
	);

endmodule

`default_nettype wire

// File: logic/palette_pkg.sv
`default_nettype none

package palette_pkg;

	import screen_pkg::*;

	typedef struct packed {
		logic [7:0] r;
		logic [7:0] g;
		logic [7:0] b;
	} rgb_t;

	localparam rgb_t COL_BLACK     = 24'h000000;
	localparam rgb_t COL_WHITE     = 24'hFFFFFF;
	localparam rgb_t COL_WHITE_LIT = 24'h0080FF;
	localparam rgb_t COL_BLACK_LIT = 24'hFF8000;

	// One colour per key, indexed by control bit
	localparam rgb_t NOTE_COLOUR [NUM_KEYS] = '{
		24'hFBB735, 24'hF2A033, 24'hE98931,
		24'hEA64B6, 24'hEB403B, 24'hCF3739,
		24'hB32E37, 24'h8FAC51, 24'h6C2A6A,
		24'h643701, 24'h5C4399, 24'h41C391,
		24'h274389, 24'h235118, 24'h1F5EA8,
		24'h20EF2C, 24'h227FB0, 24'h26983A,
		24'h39C0B3, 24'h3238BC, 24'h02C874,
		24'h1E4493, 24'h009100, 24'h02C874,
		24'h737300
	};

endpackage

`default_nettype wire

// File: logic/screen_pkg.sv
`default_nettype none

package screen_pkg;

	typedef logic [10:0] coord_t;

	typedef struct packed {
		coord_t x;
		coord_t y;
	} pixel_pos_t;

	// Bit k is key k, in the Ctrl bit order of the keyboard
	typedef logic [24:0] key_mask_t;

	localparam int NUM_KEYS  = 25;
	localparam int NUM_WHITE = 15;
	localparam int NUM_BLACK = NUM_KEYS - NUM_WHITE;
	localparam int HIST_ROWS = 25;
	localparam int HIST_COLS = 50;

	localparam int PANEL_X_MAX  = 150;
	localparam int BLACK_X_MIN  = 30;
	localparam int SCREEN_Y_MAX = 450;
	localparam int WHITE_BAND   = 30;
	localparam int SEP_HALF     = 2;
	localparam int ROW_PIXELS   = 26;
	localparam int COL_PIXELS   = 10;

	localparam int WHITE_KEY_IDX [NUM_WHITE] = '{0, 2, 3, 5, 7, 8, 10, 12, 14, 15, 17, 19, 20, 22, 24};

	// Black bars span (lo, hi] in y
	localparam int BLACK_BAR_LO [NUM_BLACK] = '{20, 80, 110, 170, 200, 230, 290, 320, 380, 410};
	localparam int BLACK_BAR_HI [NUM_BLACK] = '{40, 100, 130, 190, 220, 250, 310, 340, 400, 430};
	localparam int BLACK_KEY_IDX [NUM_BLACK] = '{1, 4, 6, 9, 11, 13, 16, 18, 21, 23};

	// Separators between adjacent white keys with no black key in between
	localparam int GAP_SEP [4] = '{60, 150, 270, 360};

	localparam int NOTE_FIRST_COL [NUM_KEYS] = '{
		0, 2, 3, 6, 8, 9, 11, 12, 15, 17, 18, 20, 21,
		23, 24, 27, 29, 30, 32, 33, 36, 38, 39, 41, 42
	};
	localparam int NOTE_WIDTH [NUM_KEYS] = '{
		3, 2, 3, 3, 2, 3, 2, 3, 3, 2, 3, 2, 3,
		2, 3, 3, 2, 3, 2, 3, 3, 2, 3, 2, 3
	};

	localparam int SCROLL_PERIOD = 1 << 23;

endpackage

`default_nettype wire
